//--- joypad_top.f
src/joypad_pkg.sv
src/pad_scanner.sv
src/joypad_p1_reg.sv
src/joypad_top.sv
verification/pad_model.sv
verification/joypad_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the joypad testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=joypad_sim

verilator --binary --assert --timing \
   --top-module joypad_tb \
   -Mdir "$BUILD_DIR" \
   -o "$SIM_BIN" \
   -f joypad_top.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG_FILE"; then
   echo "testbench reported failure"
   exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG_FILE"; then
   echo "testbench did not report a result"
   exit 1
fi

exit 0

//--- src/joypad_p1_reg.sv
`timescale 1ns/1ps
`default_nettype none

// P1 joypad register with group select and press interrupt.
module joypad_p1_reg (
   input  wire logic                     I_CLK,
   input  wire logic                     I_RESET,
   input  wire joypad_pkg::ioreg_addr_t  ioreg_addr,
   input  wire joypad_pkg::ioreg_data_t  ioreg_wdata,
   input  wire logic                     ioreg_we_n,
   input  wire logic                     ioreg_re_n,
   output joypad_pkg::ioreg_data_t       ioreg_rdata,
   output logic                          pad_latch,
   output logic                          pad_pulse,
   input  wire logic                     pad_data,
   output logic                          joypad_irq
);

   joypad_pkg::buttons_t  buttons;      // latest snapshot.
   logic                  scan_done;
   logic [1:0]            select_reg;   // p1 bits 5:4.
   logic                  wr_hit;
   logic                  rd_hit;
   logic [3:0]            action_grp;
   logic [3:0]            dir_grp;
   logic [3:0]            grp_sel;
   joypad_pkg::ioreg_data_t read_val;
   logic                  any_pressed;
   logic                  any_pressed_q;

   pad_scanner i_pad_scanner (
      .I_CLK     (I_CLK),
      .I_RESET   (I_RESET),
      .pad_latch (pad_latch),
      .pad_pulse (pad_pulse),
      .pad_data  (pad_data),
      .buttons   (buttons),
      .scan_done (scan_done)
   );

   // address decode.
   assign wr_hit = ~ioreg_we_n && (ioreg_addr == joypad_pkg::P1_ADDR);
   assign rd_hit = ~ioreg_re_n && (ioreg_addr == joypad_pkg::P1_ADDR);

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         select_reg <= 2'b00;
      end else if (wr_hit) begin
         select_reg <= ioreg_wdata[5:4];
      end
   end

   // the two four-button groups.
   assign action_grp = {buttons[joypad_pkg::BTN_START], buttons[joypad_pkg::BTN_SELECT],
                        buttons[joypad_pkg::BTN_A],     buttons[joypad_pkg::BTN_B]};
   assign dir_grp    = {buttons[joypad_pkg::BTN_DOWN],  buttons[joypad_pkg::BTN_UP],
                        buttons[joypad_pkg::BTN_LEFT],  buttons[joypad_pkg::BTN_RIGHT]};

   // select bit 1 wins over bit 0.
   always_comb begin
      if (select_reg[1]) begin
         grp_sel = action_grp;
      end else if (select_reg[0]) begin
         grp_sel = dir_grp;
      end else begin
         grp_sel = 4'b0000;
      end
   end

   assign read_val    = {4'b0000, grp_sel};
   assign ioreg_rdata = rd_hit ? read_val : '0;   // zero when not addressed.

   assign any_pressed = |buttons;

   // one-cycle pulse when the snapshot goes from none to some pressed.
   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         any_pressed_q <= 1'b0;
         joypad_irq    <= 1'b0;
      end else begin
         joypad_irq <= scan_done && any_pressed && ~any_pressed_q;
         if (scan_done) begin
            any_pressed_q <= any_pressed;   // follows each new snapshot.
         end
      end
   end

endmodule

`default_nettype wire

//--- src/joypad_pkg.sv
`default_nettype none

package joypad_pkg;

   // P1 register bus.
   typedef logic [15:0] ioreg_addr_t;   // cpu i/o address.
   typedef logic [7:0]  ioreg_data_t;   // cpu i/o data.

   // one bit per button, 1 = pressed.
   typedef logic [7:0]  buttons_t;

   localparam ioreg_addr_t P1_ADDR = 16'hFF00;   // joypad register.

   // bit positions inside buttons_t.
   localparam int BTN_START  = 7;
   localparam int BTN_SELECT = 6;
   localparam int BTN_B      = 5;
   localparam int BTN_A      = 4;
   localparam int BTN_DOWN   = 3;
   localparam int BTN_UP     = 2;
   localparam int BTN_LEFT   = 1;
   localparam int BTN_RIGHT  = 0;

   // serial scan timing, all counts in ticks except SCAN_HALF.
   localparam int SCAN_HALF   = 4;    // clocks per tick.
   localparam int SCAN_GAP    = 16;   // idle ticks between scans.
   localparam int PAD_BITS    = 8;    // bits per scan.
   localparam int LATCH_TICKS = 2;    // latch high time.

   // counter widths derived from the timing above.
   localparam int TICK_W = $clog2(SCAN_HALF);
   localparam int STEP_W = $clog2(SCAN_GAP);
   localparam int BIT_W  = $clog2(PAD_BITS);

   // scanner FSM.
   typedef enum logic [1:0] {
      scan_idle  = 2'd0,   // gap between scans.
      scan_latch = 2'd1,   // latch high.
      scan_low   = 2'd2,   // pulse low, sample at end.
      scan_high  = 2'd3    // pulse high, pad shifts.
   } scan_state_t;

endpackage

`default_nettype wire

//--- src/joypad_top.sv
`timescale 1ns/1ps
`default_nettype none

// Joypad subsystem top level.
module joypad_top (
   input  wire logic                     I_CLK,
   input  wire logic                     I_RESET,

   // cpu i/o register bus.
   input  wire joypad_pkg::ioreg_addr_t  ioreg_addr,
   input  wire joypad_pkg::ioreg_data_t  ioreg_wdata,
   input  wire logic                     ioreg_we_n,
   input  wire logic                     ioreg_re_n,
   output joypad_pkg::ioreg_data_t       ioreg_rdata,

   // serial pad link.
   output logic                          pad_latch,
   output logic                          pad_pulse,
   input  wire logic                     pad_data,     // active low.

   // to cpu interrupt controller.
   output logic                          joypad_irq
);

   joypad_p1_reg i_joypad_p1_reg (
      .I_CLK       (I_CLK),
      .I_RESET     (I_RESET),
      .ioreg_addr  (ioreg_addr),
      .ioreg_wdata (ioreg_wdata),
      .ioreg_we_n  (ioreg_we_n),
      .ioreg_re_n  (ioreg_re_n),
      .ioreg_rdata (ioreg_rdata),
      .pad_latch   (pad_latch),
      .pad_pulse   (pad_pulse),
      .pad_data    (pad_data),
      .joypad_irq  (joypad_irq)
   );

endmodule

`default_nettype wire

//--- src/pad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

// Continuously scans an 8-button serial pad and keeps the last result
// in a snapshot register.
module pad_scanner (
   input  wire logic                I_CLK,
   input  wire logic                I_RESET,
   output logic                     pad_latch,
   output logic                     pad_pulse,
   input  wire logic                pad_data,
   output joypad_pkg::buttons_t     buttons,
   output logic                     scan_done
);

   logic [joypad_pkg::TICK_W-1:0] tick_cnt;   // clocks within a tick.
   logic                          tick;       // last clock of a tick.
   logic [joypad_pkg::STEP_W-1:0] step_cnt;   // ticks within idle or latch.
   logic [joypad_pkg::BIT_W-1:0]  bit_cnt;    // serial bit index.
   joypad_pkg::scan_state_t       state;
   logic [joypad_pkg::PAD_BITS-1:0] shift_reg;  // first bit ends in msb.
   logic                          scan_end;
   joypad_pkg::buttons_t          scan_buttons;
   logic                          gap_last;
   logic                          latch_last;
   logic                          bit_last;

   assign tick = (tick_cnt == joypad_pkg::TICK_W'(joypad_pkg::SCAN_HALF - 1));

   assign gap_last   = (step_cnt == joypad_pkg::STEP_W'(joypad_pkg::SCAN_GAP - 1));
   assign latch_last = (step_cnt == joypad_pkg::STEP_W'(joypad_pkg::LATCH_TICKS - 1));
   assign bit_last   = (bit_cnt == joypad_pkg::BIT_W'(joypad_pkg::PAD_BITS - 1));

   // end of the last high tick.
   assign scan_end = tick && (state == joypad_pkg::scan_high) && bit_last;

   // tick prescaler.
   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         tick_cnt <= '0;
      end else if (tick) begin
         tick_cnt <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   // scan FSM, advances only on ticks.
   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         state    <= joypad_pkg::scan_idle;
         step_cnt <= joypad_pkg::STEP_W'(joypad_pkg::SCAN_GAP - 1);  // short first gap.
         bit_cnt  <= '0;
      end else if (tick) begin
         case (state)
            joypad_pkg::scan_idle: begin
               if (gap_last) begin
                  state    <= joypad_pkg::scan_latch;
                  step_cnt <= '0;
               end else begin
                  step_cnt <= step_cnt + 1'b1;
               end
            end
            joypad_pkg::scan_latch: begin
               if (latch_last) begin
                  state   <= joypad_pkg::scan_low;
                  bit_cnt <= '0;
               end else begin
                  step_cnt <= step_cnt + 1'b1;
               end
            end
            joypad_pkg::scan_low: begin
               state <= joypad_pkg::scan_high;
            end
            joypad_pkg::scan_high: begin
               if (bit_last) begin
                  state    <= joypad_pkg::scan_idle;
                  step_cnt <= '0;
               end else begin
                  state   <= joypad_pkg::scan_low;
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
            default: begin
               state <= joypad_pkg::scan_idle;
            end
         endcase
      end
   end

   // pad drive straight from the state register.
   assign pad_latch = (state == joypad_pkg::scan_latch);
   assign pad_pulse = (state == joypad_pkg::scan_high);

   // sample at the end of each low tick, data is active low.
   always_ff @(posedge I_CLK) begin
      if (tick && (state == joypad_pkg::scan_low)) begin
         shift_reg <= {shift_reg[joypad_pkg::PAD_BITS-2:0], ~pad_data};
      end
   end

   // serial order is a, b, select, start, up, down, left, right.
   assign scan_buttons[joypad_pkg::BTN_A]      = shift_reg[7];
   assign scan_buttons[joypad_pkg::BTN_B]      = shift_reg[6];
   assign scan_buttons[joypad_pkg::BTN_SELECT] = shift_reg[5];
   assign scan_buttons[joypad_pkg::BTN_START]  = shift_reg[4];
   assign scan_buttons[joypad_pkg::BTN_UP]     = shift_reg[3];
   assign scan_buttons[joypad_pkg::BTN_DOWN]   = shift_reg[2];
   assign scan_buttons[joypad_pkg::BTN_LEFT]   = shift_reg[1];
   assign scan_buttons[joypad_pkg::BTN_RIGHT]  = shift_reg[0];

   // snapshot and done strobe update together.
   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         buttons   <= '0;
         scan_done <= 1'b0;
      end else begin
         scan_done <= scan_end;
         if (scan_end) begin
            buttons <= scan_buttons;
         end
      end
   end

endmodule

`default_nettype wire

//--- verification/joypad_tb.sv
`timescale 1ns/1ps
`default_nettype none

module joypad_tb;

   localparam int SCAN_CYCLES = (joypad_pkg::LATCH_TICKS + 2 * joypad_pkg::PAD_BITS
                                 + joypad_pkg::SCAN_GAP) * joypad_pkg::SCAN_HALF;
   localparam int CYCLE_LIMIT = 40 * SCAN_CYCLES;   // 40 scans.
   localparam int ROUNDS      = 6;

   logic                    I_CLK = 1'b0;
   logic                    I_RESET;
   joypad_pkg::ioreg_addr_t ioreg_addr;
   joypad_pkg::ioreg_data_t ioreg_wdata;
   logic                    ioreg_we_n;
   logic                    ioreg_re_n;
   joypad_pkg::ioreg_data_t ioreg_rdata;
   logic                    pad_latch;
   logic                    pad_pulse;
   logic                    pad_data;
   logic                    joypad_irq;
   joypad_pkg::buttons_t    pressed;      // vector held by the pad.

   integer                  seed;
   int                      cycle_cnt;
   int                      err_overlap;
   int                      err_pulses;
   int                      err_irq;
   int                      err_reset;
   int                      err_read;

   // reference tracking of the serial scans.
   logic                    latch_q;
   logic                    pulse_q;
   logic                    seen_latch;
   int                      pulse_cnt;
   int                      scan_count;
   joypad_pkg::buttons_t    latched_vec;
   joypad_pkg::buttons_t    snap_exp;
   logic                    irq_exp;

   joypad_pkg::buttons_t    v1;
   joypad_pkg::buttons_t    v2;

   joypad_top i_joypad_top (
      .I_CLK       (I_CLK),
      .I_RESET     (I_RESET),
      .ioreg_addr  (ioreg_addr),
      .ioreg_wdata (ioreg_wdata),
      .ioreg_we_n  (ioreg_we_n),
      .ioreg_re_n  (ioreg_re_n),
      .ioreg_rdata (ioreg_rdata),
      .pad_latch   (pad_latch),
      .pad_pulse   (pad_pulse),
      .pad_data    (pad_data),
      .joypad_irq  (joypad_irq)
   );

   pad_model i_pad_model (
      .pad_latch (pad_latch),
      .pad_pulse (pad_pulse),
      .pad_data  (pad_data),
      .pressed   (pressed)
   );

   always #10 I_CLK = ~I_CLK;

   // snapshot loads as the 8th pulse ends and irq follows one edge later.
   always @(posedge I_CLK) begin
      latch_q <= pad_latch;
      pulse_q <= pad_pulse;
      irq_exp <= 1'b0;
      if (I_RESET) begin
         seen_latch <= 1'b0;
         pulse_cnt  <= 0;
         scan_count <= 0;
         snap_exp   <= '0;
      end else begin
         if (pad_latch && !latch_q) begin
            latched_vec <= pressed;
            seen_latch  <= 1'b1;
            pulse_cnt   <= 0;
         end else if (pad_pulse && !pulse_q) begin
            pulse_cnt <= pulse_cnt + 1;
         end
         if (!pad_pulse && pulse_q && (pulse_cnt == joypad_pkg::PAD_BITS)) begin
            snap_exp   <= latched_vec;
            irq_exp    <= (latched_vec != '0) && (snap_exp == '0);
            scan_count <= scan_count + 1;
         end
      end
   end

   assert property (@(posedge I_CLK) !(pad_latch && pad_pulse))
      else begin
         err_overlap++;
         $display("latch and pulse were high in the same cycle");
      end

   assert property (@(posedge I_CLK) disable iff (I_RESET)
                    (pad_latch && !latch_q && seen_latch) |-> (pulse_cnt == joypad_pkg::PAD_BITS))
      else begin
         err_pulses++;
         $display("mismatch pulse count: expected %0d, actual %0d",
                  joypad_pkg::PAD_BITS, $sampled(pulse_cnt));
      end

   assert property (@(posedge I_CLK) disable iff (I_RESET) joypad_irq == irq_exp)
      else begin
         err_irq++;
         $display("mismatch irq: expected %0b, actual %0b",
                  $sampled(irq_exp), $sampled(joypad_irq));
      end

   assert property (@(posedge I_CLK) $past(I_RESET) |-> (!pad_latch && !pad_pulse && !joypad_irq))
      else begin
         err_reset++;
         $display("pad outputs or irq were not low in or right after reset");
      end

   // read value from the P1 group rules.
   function automatic joypad_pkg::ioreg_data_t expected_read(input logic [1:0] sel,
                                                             input joypad_pkg::buttons_t v);
      if (sel[1]) begin
         return {4'b0000, v[joypad_pkg::BTN_START], v[joypad_pkg::BTN_SELECT],
                 v[joypad_pkg::BTN_A], v[joypad_pkg::BTN_B]};
      end else if (sel[0]) begin
         return {4'b0000, v[joypad_pkg::BTN_DOWN], v[joypad_pkg::BTN_UP],
                 v[joypad_pkg::BTN_LEFT], v[joypad_pkg::BTN_RIGHT]};
      end
      return 8'h00;
   endfunction

   function automatic joypad_pkg::buttons_t random_pressed();
      joypad_pkg::buttons_t v;
      v = joypad_pkg::buttons_t'($random(seed));
      if (v == '0) begin
         v = 8'h01;   // keep at least one button down.
      end
      return v;
   endfunction

   task automatic check_value(input string name, input joypad_pkg::ioreg_data_t expected,
                              input joypad_pkg::ioreg_data_t actual);
      assert (actual == expected)
         else begin
            err_read++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
         end
   endtask

   task automatic write_reg(input joypad_pkg::ioreg_addr_t addr,
                            input joypad_pkg::ioreg_data_t data);
      @(posedge I_CLK);
      ioreg_addr  <= addr;
      ioreg_wdata <= data;
      ioreg_we_n  <= 1'b0;
      @(posedge I_CLK);
      ioreg_we_n  <= 1'b1;
   endtask

   // rdata is combinational and checked mid-cycle.
   task automatic check_read(input string name, input joypad_pkg::ioreg_addr_t addr,
                             input logic re_n, input joypad_pkg::ioreg_data_t expected);
      @(posedge I_CLK);
      ioreg_addr <= addr;
      ioreg_re_n <= re_n;
      @(negedge I_CLK);
      check_value(name, expected, ioreg_rdata);
      @(posedge I_CLK);
      ioreg_re_n <= 1'b1;
   endtask

   task automatic check_groups(input joypad_pkg::buttons_t v);
      logic [7:0] noise;
      noise = 8'($random(seed));   // other wdata bits must not matter.
      write_reg(joypad_pkg::P1_ADDR, {noise[7:6], 2'b10, noise[3:0]});
      check_read("select 10", joypad_pkg::P1_ADDR, 1'b0, expected_read(2'b10, v));
      write_reg(joypad_pkg::P1_ADDR, {noise[7:6], 2'b01, noise[3:0]});
      check_read("select 01", joypad_pkg::P1_ADDR, 1'b0, expected_read(2'b01, v));
      write_reg(joypad_pkg::P1_ADDR, {noise[7:6], 2'b11, noise[3:0]});
      check_read("select 11", joypad_pkg::P1_ADDR, 1'b0, expected_read(2'b10, v));
      write_reg(joypad_pkg::P1_ADDR, {noise[7:6], 2'b00, noise[3:0]});
      check_read("select 00", joypad_pkg::P1_ADDR, 1'b0, 8'h00);
   endtask

   task automatic check_decode(input joypad_pkg::buttons_t v);
      joypad_pkg::ioreg_addr_t other;
      logic [1:0]              sel;
      other = 16'($random(seed));
      if (other == joypad_pkg::P1_ADDR) begin
         other = other ^ 16'h0001;
      end
      sel = (v[3:0] != 4'h0) ? 2'b01 : 2'b10;   // a group that reads nonzero.
      write_reg(joypad_pkg::P1_ADDR, {2'b00, sel, 4'h0});
      write_reg(other, 8'h00);   // must be ignored.
      check_read("foreign write", joypad_pkg::P1_ADDR, 1'b0, expected_read(sel, v));
      check_read("foreign read", other, 1'b0, 8'h00);
      check_read("read disabled", joypad_pkg::P1_ADDR, 1'b1, 8'h00);
   endtask

   task automatic wait_scan_end();
      int start;
      start = scan_count;
      while (scan_count == start) begin
         @(posedge I_CLK);
      end
   endtask

   task automatic report_counts();
      $display("errors: overlap %0d, pulses %0d, irq %0d, reset %0d, read %0d",
               err_overlap, err_pulses, err_irq, err_reset, err_read);
   endtask

   always @(posedge I_CLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
         report_counts();
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial begin
      seed = 32'h7e0a4e75;
      I_RESET     <= 1'b1;
      ioreg_addr  <= '0;
      ioreg_wdata <= '0;
      ioreg_we_n  <= 1'b1;
      ioreg_re_n  <= 1'b1;
      pressed     <= '0;
      @(posedge I_CLK);
      ioreg_addr <= joypad_pkg::P1_ADDR;
      ioreg_re_n <= 1'b0;
      @(negedge I_CLK);
      check_value("read in reset", 8'h00, ioreg_rdata);
      @(posedge I_CLK);
      I_RESET    <= 1'b0;   // two reset edges.
      ioreg_re_n <= 1'b1;
      check_read("read after reset", joypad_pkg::P1_ADDR, 1'b0, 8'h00);
      wait_scan_end();
      for (int i = 0; i < ROUNDS; i++) begin
         v1 = random_pressed();
         pressed <= v1;        // changed in the idle gap.
         wait_scan_end();      // first press raises irq.
         check_groups(v1);
         check_decode(v1);
         wait_scan_end();      // held buttons raise no irq.
         v2 = random_pressed();
         if (v2 == v1) begin
            v2 = (v1 == 8'h01) ? 8'h02 : 8'h01;
         end
         pressed <= v2;
         wait_scan_end();      // nonzero change raises no irq.
         pressed <= '0;
         check_groups(v2);     // snapshot still v2 until the next scan ends.
         wait_scan_end();
      end
      repeat (4) @(posedge I_CLK);
      report_counts();
      if ((err_overlap + err_pulses + err_irq + err_reset + err_read) == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/pad_model.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral 8-button serial pad with an active-low data line.
module pad_model (
   input  wire logic                  pad_latch,
   input  wire logic                  pad_pulse,
   output logic                       pad_data,
   input  wire joypad_pkg::buttons_t  pressed   // 1 = pressed.
);

   logic [7:0] shift_q;    // serial order, first bit in msb.
   logic [7:0] serial_vec;

   // serial order is a, b, select, start, up, down, left, right.
   assign serial_vec = {pressed[joypad_pkg::BTN_A],
                        pressed[joypad_pkg::BTN_B],
                        pressed[joypad_pkg::BTN_SELECT],
                        pressed[joypad_pkg::BTN_START],
                        pressed[joypad_pkg::BTN_UP],
                        pressed[joypad_pkg::BTN_DOWN],
                        pressed[joypad_pkg::BTN_LEFT],
                        pressed[joypad_pkg::BTN_RIGHT]};

   initial begin
      shift_q = 8'h00;   // released until the first latch.
   end

   // load on latch, advance one bit on each pulse rise.
   always @(posedge pad_latch or posedge pad_pulse) begin
      if (pad_latch) begin
         shift_q <= serial_vec;
      end else begin
         shift_q <= {shift_q[6:0], 1'b0};
      end
   end

   assign pad_data = ~shift_q[7];   // low means pressed.

endmodule

`default_nettype wire
